// ==== Makefile ====
# Verilator build and run of the leg IK testbench

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module leg_ik_tb -f leg_ik.f

run: compile
	./obj_dir/Vleg_ik_tb | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

// ==== hw/ik_cordic_atan.sv ====
/*
 * atan2(y, x) over the full circle, done CORDIC_ITERS + 2 cycles after start.
 * Operand magnitudes must stay below 2**30. The result for x = y = 0 is not defined.
 */
`default_nettype none
`timescale 1ns/1ps

module ik_cordic_atan (
	input  wire                    clk_in,
	input  wire                    _reset_in,
	input  wire                    start_i,
	input  wire leg_ik_pkg::wide_t x_i,
	input  wire leg_ik_pkg::wide_t y_i,
	output logic                   done_o,
	output leg_ik_pkg::phase_t     phase_o
);

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_ITER,
		CS_ROUND
	} cordic_state_t;

	// Two guard bits for the CORDIC gain
	typedef logic signed [leg_ik_pkg::WIDE_WIDTH+1:0] vec_t;
	// Accumulated angle, 2**32 per turn
	typedef logic [31:0] angle_t;

	// atan(2**-i) scaled to angle_t
	localparam angle_t ATAN_TABLE [leg_ik_pkg::CORDIC_ITERS] = '{
		32'h2000_0000, 32'h12E4_051E, 32'h09FB_385B, 32'h0511_11D4,
		32'h028B_0D43, 32'h0145_D7E1, 32'h00A2_F61E, 32'h0051_7C55,
		32'h0028_BE53, 32'h0014_5F2F, 32'h000A_2F98, 32'h0005_17CC,
		32'h0002_8BE6, 32'h0001_45F3, 32'h0000_A2FA, 32'h0000_517D
	};

	cordic_state_t                                   state_q;
	logic [$clog2(leg_ik_pkg::CORDIC_ITERS)-1:0]     iter_q;
	vec_t                                            x_q;
	vec_t                                            y_q;
	angle_t                                          z_q;
	vec_t                                            x_in;
	vec_t                                            y_in;
	vec_t                                            x_sh;
	vec_t                                            y_sh;

	assign x_in = vec_t'(x_i);
	assign y_in = vec_t'(y_i);
	assign x_sh = x_q >>> iter_q;
	assign y_sh = y_q >>> iter_q;

	always_ff @(posedge clk_in or negedge _reset_in) begin
		if (!_reset_in) begin
			state_q <= CS_IDLE;
			iter_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				CS_IDLE: begin
					iter_q <= '0;
					if (start_i) begin
						state_q <= CS_ITER;
					end
				end
				CS_ITER: begin
					iter_q <= iter_q + 1'b1;
					if (iter_q == leg_ik_pkg::CORDIC_ITERS - 1) begin
						state_q <= CS_ROUND;
					end
				end
				CS_ROUND: begin
					done_o  <= 1'b1;
					state_q <= CS_IDLE;
				end
				default: state_q <= CS_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Datapath
	// ------------------------------
	always_ff @(posedge clk_in) begin
		case (state_q)
			CS_IDLE: begin
				if (start_i) begin
					// Quarter turn into the right half-plane
					if (!x_in[$bits(vec_t)-1]) begin
						x_q <= x_in;
						y_q <= y_in;
						z_q <= 32'h0000_0000;
					end else if (!y_in[$bits(vec_t)-1]) begin
						x_q <= y_in;
						y_q <= -x_in;
						z_q <= 32'h4000_0000;
					end else begin
						x_q <= -y_in;
						y_q <= x_in;
						z_q <= 32'hC000_0000;
					end
				end
			end
			CS_ITER: begin
				// Drive y toward zero
				if (y_q[$bits(vec_t)-1]) begin
					x_q <= x_q - y_sh;
					y_q <= y_q + x_sh;
					z_q <= z_q - ATAN_TABLE[iter_q];
				end else begin
					x_q <= x_q + y_sh;
					y_q <= y_q - x_sh;
					z_q <= z_q + ATAN_TABLE[iter_q];
				end
			end
			CS_ROUND: phase_o <= z_q[31:16] + z_q[15];
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/ik_isqrt.sv ====
/*
 * Floor square root, one result bit per cycle, done 33 cycles after start.
 * A start while busy is ignored. A negative radicand gives zero.
 */
`default_nettype none
`timescale 1ns/1ps

module ik_isqrt (
	input  wire                    clk_in,
	input  wire                    _reset_in,
	input  wire                    start_i,
	input  wire leg_ik_pkg::prod_t radicand_i,
	output logic                   done_o,
	output leg_ik_pkg::wide_t      root_o
);

	logic                                      busy_q;
	logic [$clog2(leg_ik_pkg::WIDE_WIDTH)-1:0] count_q;
	logic [leg_ik_pkg::PROD_WIDTH-1:0]         rad_q;
	logic [leg_ik_pkg::WIDE_WIDTH+1:0]         rem_q;
	logic [leg_ik_pkg::WIDE_WIDTH-1:0]         root_q;
	logic [leg_ik_pkg::WIDE_WIDTH+3:0]         rem_shift;
	logic [leg_ik_pkg::WIDE_WIDTH+3:0]         trial;
	logic [leg_ik_pkg::WIDE_WIDTH+3:0]         rem_next;
	logic                                      fits;

	// Bring down the next two radicand bits and try 4*root+1
	assign rem_shift = {rem_q, rad_q[leg_ik_pkg::PROD_WIDTH-1 -: 2]};
	assign trial     = {2'b00, root_q, 2'b01};
	assign fits      = (rem_shift >= trial);
	assign rem_next  = fits ? (rem_shift - trial) : rem_shift;

	always_ff @(posedge clk_in or negedge _reset_in) begin
		if (!_reset_in) begin
			busy_q  <= 1'b0;
			count_q <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i && !busy_q) begin
				busy_q  <= 1'b1;
				count_q <= '1;
			end else if (busy_q) begin
				count_q <= count_q - 1'b1;
				if (count_q == '0) begin
					busy_q <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (start_i && !busy_q) begin
			rad_q  <= radicand_i[leg_ik_pkg::PROD_WIDTH-1] ? '0 : radicand_i;
			rem_q  <= '0;
			root_q <= '0;
		end else if (busy_q) begin
			rad_q  <= rad_q << 2;
			// Remainder never exceeds 2*root, so the top bits drop safely
			rem_q  <= rem_next[leg_ik_pkg::WIDE_WIDTH+1:0];
			root_q <= {root_q[leg_ik_pkg::WIDE_WIDTH-2:0], fits};
		end
	end

	assign root_o = root_q;

endmodule

`default_nettype wire

// ==== hw/ik_mult_pipe.sv ====
/*
 * Signed 32x32 multiply, result MULT_LATENCY cycles after the operands.
 * A new pair may enter every cycle and there is no stall.
 */
`default_nettype none
`timescale 1ns/1ps

module ik_mult_pipe (
	input  wire                    clk_in,
	input  wire                    _reset_in,
	input  wire                    mul_valid_i,
	input  wire leg_ik_pkg::wide_t mul_a_i,
	input  wire leg_ik_pkg::wide_t mul_b_i,
	output logic                   mul_valid_o,
	output leg_ik_pkg::prod_t      mul_p_o
);

	logic [leg_ik_pkg::MULT_LATENCY-1:0] valid_sr;
	leg_ik_pkg::wide_t                   a_q;
	leg_ik_pkg::wide_t                   b_q;
	leg_ik_pkg::prod_t                   prod_q [leg_ik_pkg::MULT_LATENCY-1];

	// Valid travels alongside the data
	always_ff @(posedge clk_in or negedge _reset_in) begin
		if (!_reset_in) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[leg_ik_pkg::MULT_LATENCY-2:0], mul_valid_i};
		end
	end

	// Operand stage, multiply stage, then plain delay stages
	always_ff @(posedge clk_in) begin
		if (mul_valid_i) begin
			a_q <= mul_a_i;
			b_q <= mul_b_i;
		end
		prod_q[0] <= a_q * b_q;
		for (int i = 1; i < leg_ik_pkg::MULT_LATENCY - 1; i++) begin
			prod_q[i] <= prod_q[i-1];
		end
	end

	assign mul_valid_o = valid_sr[leg_ik_pkg::MULT_LATENCY-1];
	assign mul_p_o     = prod_q[leg_ik_pkg::MULT_LATENCY-2];

endmodule

`default_nettype wire

// ==== hw/ik_sequencer.sv ====
/*
 * Starts are taken only while idle. Results depend on the fixed unit latencies.
 * The theta outputs update only on a successful done, never on no-solution.
 */
`default_nettype none
`timescale 1ns/1ps

module ik_sequencer (
	input  wire                     clk_in,
	input  wire                     _reset_in,
	input  wire                     start_i,
	input  wire leg_ik_pkg::pos_t   x_i,
	input  wire leg_ik_pkg::pos_t   y_i,
	input  wire leg_ik_pkg::pos_t   z_i,
	output logic                    mul_valid_o,
	output leg_ik_pkg::wide_t       mul_a_o,
	output leg_ik_pkg::wide_t       mul_b_o,
	input  wire                     mul_valid_i,
	input  wire leg_ik_pkg::prod_t  mul_p_i,
	output logic                    sqrt_start_o,
	output leg_ik_pkg::prod_t       sqrt_radicand_o,
	input  wire                     sqrt_done_i,
	input  wire leg_ik_pkg::wide_t  sqrt_root_i,
	output logic                    atan_start_o,
	output leg_ik_pkg::wide_t       atan_x_o,
	output leg_ik_pkg::wide_t       atan_y_o,
	input  wire                     atan_done_i,
	input  wire leg_ik_pkg::phase_t atan_phase_i,
	output logic                    done_o,
	output logic                    no_solution_o,
	output leg_ik_pkg::phase_t      theta1_o,
	output leg_ik_pkg::phase_t      theta2_o,
	output leg_ik_pkg::phase_t      theta3_o
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_SQ_A,
		S_SQ_B,
		S_SQ_WAIT,
		S_ROOT_XY,
		S_WAIT_XY,
		S_CHECK,
		S_MUL_C1,
		S_WAIT_C1,
		S_ROOT_C2,
		S_WAIT_C2,
		S_ATAN,
		S_WAIT_ATAN
	} seq_state_t;

	seq_state_t         state_q;
	logic               pair_q;       // 0 squares x and y, 1 squares r and z
	logic               got_first_q;
	logic               sqrt_seen_q;
	logic               atan_seen_q;
	logic [1:0]         atan_step_q;  // theta3, then the two theta2 terms
	logic               out_of_reach;
	leg_ik_pkg::pos_t   x_q;
	leg_ik_pkg::pos_t   y_q;
	leg_ik_pkg::pos_t   z_q;
	leg_ik_pkg::prod_t  sum_q;        // x^2+y^2, then d^2, then the c2 radicand
	leg_ik_pkg::wide_t  r_q;
	leg_ik_pkg::wide_t  c1_q;
	leg_ik_pkg::wide_t  c2_q;
	leg_ik_pkg::phase_t phi1_q;
	leg_ik_pkg::phase_t phi2_q;
	leg_ik_pkg::phase_t phi3_q;

	// ------------------------------
	// Unit requests
	// ------------------------------
	assign mul_valid_o = (state_q == S_SQ_A) || (state_q == S_SQ_B) || (state_q == S_MUL_C1);

	// Every product here is a square
	always_comb begin
		mul_a_o = c1_q;
		case (state_q)
			S_SQ_A: mul_a_o = pair_q ? r_q : leg_ik_pkg::wide_t'(x_q);
			S_SQ_B: mul_a_o = pair_q ? leg_ik_pkg::wide_t'(z_q) : leg_ik_pkg::wide_t'(y_q);
			default: ;
		endcase
	end
	assign mul_b_o = mul_a_o;

	assign sqrt_start_o    = (state_q == S_ROOT_XY) || (state_q == S_ROOT_C2);
	assign sqrt_radicand_o = sum_q;
	assign atan_start_o    = (state_q == S_ROOT_XY) || (state_q == S_ATAN);

	always_comb begin
		atan_x_o = c1_q;
		atan_y_o = c2_q;
		if (state_q == S_ROOT_XY) begin
			atan_x_o = leg_ik_pkg::wide_t'(x_q);
			atan_y_o = leg_ik_pkg::wide_t'(y_q);
		end else if (atan_step_q == 2'd1) begin
			atan_x_o = r_q;
			atan_y_o = -leg_ik_pkg::wide_t'(z_q);
		end else if (atan_step_q == 2'd2) begin
			atan_x_o = leg_ik_pkg::LENGTH_2_2_SQR + c1_q;
		end
	end

	assign out_of_reach = (sum_q < leg_ik_pkg::prod_t'(leg_ik_pkg::LENGTH_MIN_RAD_SQR)) ||
		(sum_q > leg_ik_pkg::prod_t'(leg_ik_pkg::LENGTH_2PLUS3_SQR));

	// ------------------------------
	// Job FSM
	// ------------------------------
	always_ff @(posedge clk_in or negedge _reset_in) begin
		if (!_reset_in) begin
			state_q       <= S_IDLE;
			pair_q        <= 1'b0;
			got_first_q   <= 1'b0;
			sqrt_seen_q   <= 1'b0;
			atan_seen_q   <= 1'b0;
			atan_step_q   <= 2'd0;
			done_o        <= 1'b0;
			no_solution_o <= 1'b0;
			theta1_o      <= '0;
			theta2_o      <= '0;
			theta3_o      <= '0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (start_i) begin
						no_solution_o <= 1'b0;
						pair_q        <= 1'b0;
						state_q       <= S_SQ_A;
					end
				end
				S_SQ_A: state_q <= S_SQ_B;
				S_SQ_B: state_q <= S_SQ_WAIT;
				S_SQ_WAIT: begin
					if (mul_valid_i) begin
						got_first_q <= !got_first_q;
						if (got_first_q) begin
							state_q <= pair_q ? S_CHECK : S_ROOT_XY;
						end
					end
				end
				S_ROOT_XY: begin
					sqrt_seen_q <= 1'b0;
					atan_seen_q <= 1'b0;
					state_q     <= S_WAIT_XY;
				end
				// Root and theta1 run side by side
				S_WAIT_XY: begin
					if (sqrt_done_i) begin
						sqrt_seen_q <= 1'b1;
					end
					if (atan_done_i) begin
						atan_seen_q <= 1'b1;
					end
					if ((sqrt_seen_q || sqrt_done_i) && (atan_seen_q || atan_done_i)) begin
						pair_q  <= 1'b1;
						state_q <= S_SQ_A;
					end
				end
				S_CHECK: begin
					if (out_of_reach) begin
						done_o        <= 1'b1;
						no_solution_o <= 1'b1;
						state_q       <= S_IDLE;
					end else begin
						state_q <= S_MUL_C1;
					end
				end
				S_MUL_C1: state_q <= S_WAIT_C1;
				S_WAIT_C1: begin
					if (mul_valid_i) begin
						state_q <= S_ROOT_C2;
					end
				end
				S_ROOT_C2: state_q <= S_WAIT_C2;
				S_WAIT_C2: begin
					if (sqrt_done_i) begin
						atan_step_q <= 2'd0;
						state_q     <= S_ATAN;
					end
				end
				S_ATAN: state_q <= S_WAIT_ATAN;
				S_WAIT_ATAN: begin
					if (atan_done_i) begin
						if (atan_step_q == 2'd2) begin
							done_o   <= 1'b1;
							theta1_o <= phi1_q;
							theta2_o <= phi2_q - atan_phase_i;
							theta3_o <= phi3_q;
							state_q  <= S_IDLE;
						end else begin
							atan_step_q <= atan_step_q + 1'b1;
							state_q     <= S_ATAN;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// ------------------------------
	// Intermediate terms
	// ------------------------------
	always_ff @(posedge clk_in) begin
		if ((state_q == S_IDLE) && start_i) begin
			x_q <= x_i;
			y_q <= y_i;
			z_q <= z_i;
		end
		if (mul_valid_i) begin
			if (state_q == S_WAIT_C1) begin
				sum_q <= leg_ik_pkg::LENGTH_SL23 - mul_p_i;
			end else if (got_first_q) begin
				sum_q <= sum_q + mul_p_i;
			end else begin
				sum_q <= mul_p_i;
			end
		end
		// Coxa joint sits on the foot ray
		if ((state_q == S_WAIT_XY) && sqrt_done_i) begin
			r_q <= sqrt_root_i - leg_ik_pkg::LENGTH_1;
		end
		if ((state_q == S_WAIT_XY) && atan_done_i) begin
			phi1_q <= atan_phase_i;
		end
		// d^2 is in reach here, so the low word holds it
		if (state_q == S_CHECK) begin
			c1_q <= sum_q[leg_ik_pkg::WIDE_WIDTH-1:0] - leg_ik_pkg::LENGTH_23_SQR;
		end
		if ((state_q == S_WAIT_C2) && sqrt_done_i) begin
			c2_q <= sqrt_root_i;
		end
		if ((state_q == S_WAIT_ATAN) && atan_done_i) begin
			if (atan_step_q == 2'd0) begin
				phi3_q <= atan_phase_i;
			end else if (atan_step_q == 2'd1) begin
				phi2_q <= atan_phase_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/leg_ik.sv ====
/*
 * One leg IK unit. done_o pulses once per accepted start and is never held.
 */
`default_nettype none
`timescale 1ns/1ps

module leg_ik (
	input  wire                     clk_in,
	input  wire                     _reset_in,
	input  wire                     start_i,
	input  wire leg_ik_pkg::pos_t   x_i,
	input  wire leg_ik_pkg::pos_t   y_i,
	input  wire leg_ik_pkg::pos_t   z_i,
	output wire                     done_o,
	output wire                     no_solution_o,
	output wire leg_ik_pkg::phase_t theta1_o,
	output wire leg_ik_pkg::phase_t theta2_o,
	output wire leg_ik_pkg::phase_t theta3_o
);

	// Multiplier
	wire                     mul_valid_req;
	wire leg_ik_pkg::wide_t  mul_a;
	wire leg_ik_pkg::wide_t  mul_b;
	wire                     mul_valid_rsp;
	wire leg_ik_pkg::prod_t  mul_p;
	// Square root
	wire                     sqrt_start;
	wire leg_ik_pkg::prod_t  sqrt_radicand;
	wire                     sqrt_done;
	wire leg_ik_pkg::wide_t  sqrt_root;
	// Arctangent
	wire                     atan_start;
	wire leg_ik_pkg::wide_t  atan_x;
	wire leg_ik_pkg::wide_t  atan_y;
	wire                     atan_done;
	wire leg_ik_pkg::phase_t atan_phase;

	ik_sequencer u_seq (
		.clk_in          (clk_in),
		._reset_in       (_reset_in),
		.start_i         (start_i),
		.x_i             (x_i),
		.y_i             (y_i),
		.z_i             (z_i),
		.mul_valid_o     (mul_valid_req),
		.mul_a_o         (mul_a),
		.mul_b_o         (mul_b),
		.mul_valid_i     (mul_valid_rsp),
		.mul_p_i         (mul_p),
		.sqrt_start_o    (sqrt_start),
		.sqrt_radicand_o (sqrt_radicand),
		.sqrt_done_i     (sqrt_done),
		.sqrt_root_i     (sqrt_root),
		.atan_start_o    (atan_start),
		.atan_x_o        (atan_x),
		.atan_y_o        (atan_y),
		.atan_done_i     (atan_done),
		.atan_phase_i    (atan_phase),
		.done_o          (done_o),
		.no_solution_o   (no_solution_o),
		.theta1_o        (theta1_o),
		.theta2_o        (theta2_o),
		.theta3_o        (theta3_o)
	);

	ik_mult_pipe u_mult (
		.clk_in      (clk_in),
		._reset_in   (_reset_in),
		.mul_valid_i (mul_valid_req),
		.mul_a_i     (mul_a),
		.mul_b_i     (mul_b),
		.mul_valid_o (mul_valid_rsp),
		.mul_p_o     (mul_p)
	);

	ik_isqrt u_sqrt (
		.clk_in     (clk_in),
		._reset_in  (_reset_in),
		.start_i    (sqrt_start),
		.radicand_i (sqrt_radicand),
		.done_o     (sqrt_done),
		.root_o     (sqrt_root)
	);

	ik_cordic_atan u_atan (
		.clk_in    (clk_in),
		._reset_in (_reset_in),
		.start_i   (atan_start),
		.x_i       (atan_x),
		.y_i       (atan_y),
		.done_o    (atan_done),
		.phase_o   (atan_phase)
	);

endmodule

`default_nettype wire

// ==== hw/leg_ik_pkg.sv ====
/*
 * Coordinates are signed 1/16 mm units. A phase wraps at 65536 per turn.
 * Leg lengths are fixed here and all squared terms are derived from them.
 */
`default_nettype none

package leg_ik_pkg;

	// ------------------------------
	// Widths and types
	// ------------------------------
	localparam int POS_WIDTH   = 16;
	localparam int WIDE_WIDTH  = 32;
	localparam int PROD_WIDTH  = 64;
	localparam int PHASE_WIDTH = 16;

	typedef logic signed [POS_WIDTH-1:0]  pos_t;
	typedef logic signed [WIDE_WIDTH-1:0] wide_t;
	typedef logic signed [PROD_WIDTH-1:0] prod_t;
	// Full circle is 2**PHASE_WIDTH
	typedef logic [PHASE_WIDTH-1:0]       phase_t;

	// ------------------------------
	// Leg geometry
	// ------------------------------
	localparam int LENGTH_1   = 848;   // 53.00 mm coxa
	localparam int LENGTH_2   = 1060;  // 66.25 mm femur
	localparam int LENGTH_3   = 2123;  // 132.69 mm tibia
	localparam int MIN_RADIUS = 1552;  // 97.00 mm

	// Derived squares
	localparam wide_t LENGTH_23_SQR      = LENGTH_2 * LENGTH_2 + LENGTH_3 * LENGTH_3;
	localparam wide_t LENGTH_2PLUS3_SQR  = (LENGTH_2 + LENGTH_3) * (LENGTH_2 + LENGTH_3);
	localparam wide_t LENGTH_MIN_RAD_SQR = MIN_RADIUS * MIN_RADIUS;
	localparam wide_t LENGTH_2_2_SQR     = 2 * LENGTH_2 * LENGTH_2;

	// Needs 45 bits
	localparam prod_t LENGTH_SL23 = prod_t'(4) * LENGTH_2 * LENGTH_2 * LENGTH_3 * LENGTH_3;

	// ------------------------------
	// Arithmetic unit timing
	// ------------------------------
	localparam int MULT_LATENCY = 4;   // At least 2
	localparam int CORDIC_ITERS = 16;

endpackage

`default_nettype wire

// ==== leg_ik.f ====
hw/leg_ik_pkg.sv
hw/ik_mult_pipe.sv
hw/ik_isqrt.sv
hw/ik_cordic_atan.sv
hw/ik_sequencer.sv
hw/leg_ik.sv
tests/leg_ik_chk.sv
tests/leg_ik_tb.sv

// ==== tests/leg_ik_chk.sv ====
/*
 * Bound into leg_ik. Accepted starts are tracked here from start_i and done_o.
 */
`default_nettype none
`timescale 1ns/1ps

module leg_ik_chk (
	input wire                     clk_in,
	input wire                     _reset_in,
	input wire                     start_i,
	input wire                     done_o,
	input wire                     no_solution_o,
	input wire leg_ik_pkg::phase_t theta1_o,
	input wire leg_ik_pkg::phase_t theta2_o,
	input wire leg_ik_pkg::phase_t theta3_o
);

	logic busy_q;
	logic start_taken;

	// Unit is idle again in the cycle done_o shows
	assign start_taken = start_i && (!busy_q || done_o);

	always_ff @(posedge clk_in or negedge _reset_in) begin
		if (!_reset_in) begin
			busy_q <= 1'b0;
		end else if (start_taken) begin
			busy_q <= 1'b1;
		end else if (done_o) begin
			busy_q <= 1'b0;
		end
	end

	// ------------------------------
	done_one_cycle: assert property (@(posedge clk_in) disable iff (!_reset_in)
		done_o |=> !done_o)
		else $error("done_o stayed high for two cycles");

	theta_on_done: assert property (@(posedge clk_in) disable iff (!_reset_in)
		!$stable({theta1_o, theta2_o, theta3_o}) |-> done_o)
		else $error("theta outputs changed outside a done cycle");

	flag_on_done_or_start: assert property (@(posedge clk_in) disable iff (!_reset_in)
		!$stable(no_solution_o) |-> (done_o || $past(start_taken)))
		else $error("no_solution_o changed outside done or start");

endmodule

`default_nettype wire

// ==== tests/leg_ik_input.txt ====
// x y z no_solution theta1 theta2 theta3, hex, coordinates as 16-bit two's complement
// theta columns are 0000 when no_solution is 1 since the outputs keep their last values
0708 0960 0000 0 25C8 CB49 4920
F880 05A0 0610 0 65C8 ACC3 4767
FA60 F880 F9F0 0 A5C8 ECC3 4767
0960 F8F8 0000 0 E5C8 CB49 4920
1194 0000 0000 1 0000 0000 0000
0000 0800 F9C0 0 4000 EBBA 4F1B
07D0 0000 0000 1 0000 0000 0000
F800 0000 0640 0 8000 A02A 4F1B
0000 F448 F63C 1 0000 0000 0000
FA24 0000 01F4 1 0000 0000 0000
0000 F800 F9C0 0 C000 EBBA 4F1B
0800 0000 0640 0 0000 A02A 4F1B
05A0 0780 F9F0 0 25C8 ECC3 4767
F8F8 F6A0 0000 0 A5C8 CB49 4920
0000 0BB8 0000 0 4000 CB49 4920
F448 0000 0000 0 8000 CB49 4920

// ==== tests/leg_ik_tb.sv ====
/*
 * Runs every vector of tests/leg_ik_input.txt as one job, from the project root.
 * Phases are compared modulo one turn. A no-solution job must leave the phases alone.
 */
`default_nettype none
`timescale 1ns/1ps

module leg_ik_tb;

	localparam int PHASE_TOL         = 32;
	localparam int RESET_CYCLES      = 10;
	localparam int CYCLES_PER_VECTOR = 200;

	logic               clk_in = 1'b0;
	logic               _reset_in;
	logic               start_i;
	leg_ik_pkg::pos_t   x_i;
	leg_ik_pkg::pos_t   y_i;
	leg_ik_pkg::pos_t   z_i;
	wire                done_o;
	wire                no_solution_o;
	leg_ik_pkg::phase_t theta1_o;
	leg_ik_pkg::phase_t theta2_o;
	leg_ik_pkg::phase_t theta3_o;

	// One queue per column of the vector file
	int vec_x[$];
	int vec_y[$];
	int vec_z[$];
	int vec_flag[$];
	int vec_t1[$];
	int vec_t2[$];
	int vec_t3[$];

	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int done_count  = 0;
	int job_count   = 0;
	// Phases the DUT should hold after a no-solution job
	int hold_t1     = 0;
	int hold_t2     = 0;
	int hold_t3     = 0;

	always #20 clk_in = ~clk_in;

	leg_ik u_dut (
		.clk_in        (clk_in),
		._reset_in     (_reset_in),
		.start_i       (start_i),
		.x_i           (x_i),
		.y_i           (y_i),
		.z_i           (z_i),
		.done_o        (done_o),
		.no_solution_o (no_solution_o),
		.theta1_o      (theta1_o),
		.theta2_o      (theta2_o),
		.theta3_o      (theta3_o)
	);

	bind leg_ik leg_ik_chk u_chk (
		.clk_in        (clk_in),
		._reset_in     (_reset_in),
		.start_i       (start_i),
		.done_o        (done_o),
		.no_solution_o (no_solution_o),
		.theta1_o      (theta1_o),
		.theta2_o      (theta2_o),
		.theta3_o      (theta3_o)
	);

	always @(posedge clk_in) begin
		if (done_o) begin
			done_count <= done_count + 1;
		end
	end

	// Run limit
	always @(posedge clk_in) begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
			$display("Timeout: the jobs did not complete within %0d clock cycles", cycle_limit);
			$display("Summary: %0d errors, %0d vectors, %0d done pulses", error_count,
				vec_x.size(), done_count);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic compare_value(input string what, input int got, input int want, input int tol);
		int diff;
		diff = got - want;
		// Phases wrap at one full turn
		if (diff > 32767) begin
			diff -= 65536;
		end else if (diff < -32768) begin
			diff += 65536;
		end
		if (diff < 0) begin
			diff = -diff;
		end
		if (diff > tol) begin
			error_count++;
			$display("error at %0t: %s is %0h, expected %0h within %0d", $time, what, got, want,
				tol);
		end
	endtask

	task automatic load_vectors();
		int    fd;
		int    n;
		int    v0, v1, v2, v3, v4, v5, v6;
		string line;
		fd = $fopen("tests/leg_ik_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/leg_ik_input.txt, so no vectors were run");
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6);
				// Comment lines match nothing
				if (n == 7) begin
					vec_x.push_back(v0);
					vec_y.push_back(v1);
					vec_z.push_back(v2);
					vec_flag.push_back(v3);
					vec_t1.push_back(v4);
					vec_t2.push_back(v5);
					vec_t3.push_back(v6);
				end
			end
			$fclose(fd);
			if (vec_x.size() == 0) begin
				$display("The vector file holds no vectors");
				error_count++;
			end
		end
	endtask

	task automatic run_vector(input int idx);
		int gap;
		gap = $urandom % 6;
		repeat (gap) @(negedge clk_in);
		x_i     = leg_ik_pkg::pos_t'(vec_x[idx]);
		y_i     = leg_ik_pkg::pos_t'(vec_y[idx]);
		z_i     = leg_ik_pkg::pos_t'(vec_z[idx]);
		start_i = 1'b1;
		@(negedge clk_in);
		start_i = 1'b0;
		job_count++;
		// Stray starts with other coordinates while the job runs
		if ((idx % 2) == 1) begin
			repeat (3) begin
				@(negedge clk_in);
				x_i     = ~x_i;
				y_i     = -y_i;
				z_i     = z_i + 16'sd100;
				start_i = 1'b1;
				@(negedge clk_in);
				start_i = 1'b0;
			end
		end
		while (!done_o) begin
			@(negedge clk_in);
		end
		compare_value($sformatf("vector %0d no_solution", idx), no_solution_o, vec_flag[idx], 0);
		if (vec_flag[idx] == 0) begin
			hold_t1 = vec_t1[idx];
			hold_t2 = vec_t2[idx];
			hold_t3 = vec_t3[idx];
		end
		compare_value($sformatf("vector %0d theta1", idx), theta1_o, hold_t1, PHASE_TOL);
		compare_value($sformatf("vector %0d theta2", idx), theta2_o, hold_t2, PHASE_TOL);
		compare_value($sformatf("vector %0d theta3", idx), theta3_o, hold_t3, PHASE_TOL);
	endtask

	initial begin
		void'($urandom(48));
		_reset_in  = 1'b0;
		start_i    = 1'b0;
		x_i        = '0;
		y_i        = '0;
		z_i        = '0;
		load_vectors();
		cycle_limit = CYCLES_PER_VECTOR * vec_x.size() + RESET_CYCLES;
		repeat (RESET_CYCLES) @(negedge clk_in);
		_reset_in = 1'b1;
		for (int i = 0; i < vec_x.size(); i++) begin
			run_vector(i);
		end
		repeat (3) @(negedge clk_in);
		compare_value("done pulse count", done_count, job_count, 0);
		$display("Summary: %0d errors, %0d vectors, %0d done pulses", error_count, vec_x.size(),
			done_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
